//--- logic/flash_pkg.sv
package flash_pkg;

	// flash command words
	localparam logic [15:0] CMD_READ_ARRAY = 16'h00FF;
	localparam logic [15:0] CMD_PROGRAM = 16'h0040;
	localparam logic [15:0] CMD_ERASE_SETUP = 16'h0020;
	localparam logic [15:0] CMD_ERASE_CONFIRM = 16'h00D0;
	localparam logic [15:0] CMD_READ_STATUS = 16'h0070;
	localparam logic [15:0] CMD_CLEAR_STATUS = 16'h0050;

	// register byte offsets on the AXI side
	localparam logic [7:0] REG_ADDR = 8'h00;
	localparam logic [7:0] REG_WDATA = 8'h04;
	localparam logic [7:0] REG_CMD = 8'h08;
	localparam logic [7:0] REG_STATUS = 8'h0C;
	localparam logic [7:0] REG_RDATA = 8'h10;

	localparam logic [1:0] OP_READ = 2'd1;
	localparam logic [1:0] OP_PROGRAM = 2'd2;
	localparam logic [1:0] OP_ERASE = 2'd3;

	// bit positions in the status view
	localparam int SR_READY = 7;
	localparam int SR_ERASE_ERR = 5;
	localparam int SR_PROGRAM_ERR = 4;
	localparam int SR_VPP_ERR = 3;

	typedef union packed {
		logic [15:0] data;
		logic [15:0] status;
	} flash_word_t;

endpackage

//--- logic/flash_axil_regs.sv
`timescale 1ns/1ps

module flash_axil_regs #(
	parameter int ADDR_WIDTH = 22
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [7:0]            awaddr,
	input  logic                  awvalid,
	output logic                  awready,
	input  logic [31:0]           wdata,
	input  logic [3:0]            wstrb,
	input  logic                  wvalid,
	output logic                  wready,
	output logic [1:0]            bresp,
	output logic                  bvalid,
	input  logic                  bready,
	input  logic [7:0]            araddr,
	input  logic                  arvalid,
	output logic                  arready,
	output logic [31:0]           rdata,
	output logic [1:0]            rresp,
	output logic                  rvalid,
	input  logic                  rready,
	input  logic                  busy,
	input  logic                  done,
	input  logic                  rdata_valid,
	input  logic [15:0]           op_rdata,
	input  logic                  erase_err,
	input  logic                  program_err,
	input  logic                  vpp_err,
	output logic                  start,
	output logic [1:0]            op,
	output logic [ADDR_WIDTH-1:0] addr,
	output logic [15:0]           op_wdata
);

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic [31:0] addr_reg;
	logic [15:0] wdata_reg;
	logic [15:0] rdata_reg;
	logic        done_bit;
	logic        erase_bit;
	logic        program_bit;
	logic        vpp_bit;
	logic        wr_hit;
	logic        rd_hit;
	logic [31:0] status_word;

	function automatic logic mapped(input logic [7:0] offset);
		case (offset)
			flash_pkg::REG_ADDR,
			flash_pkg::REG_WDATA,
			flash_pkg::REG_CMD,
			flash_pkg::REG_STATUS,
			flash_pkg::REG_RDATA: mapped = 1'b1;
			default: mapped = 1'b0;
		endcase
	endfunction

	assign wr_hit = mapped(awaddr);
	assign rd_hit = mapped(araddr);
	assign wready = awready;

	// a command only starts on the handshake cycle, and only with a valid op while idle
	assign op = wdata[1:0];
	assign start = awready && (awaddr == flash_pkg::REG_CMD) && wstrb[0]
		&& (op != 2'b00) && !busy;

	assign addr = addr_reg[ADDR_WIDTH-1:0];
	assign op_wdata = wdata_reg;
	assign status_word = {27'd0, erase_bit, program_bit, vpp_bit, done_bit, busy};

	always_ff @(posedge clk) begin
		if (reset) begin
			awready <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			awready <= awvalid && wvalid && !awready && !bvalid;
			if (awready)
				bvalid <= 1'b1;
			else if (bvalid && bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (awready) begin
			bresp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
			if (awaddr == flash_pkg::REG_ADDR) begin
				for (int i = 0; i < 4; i++)
					if (wstrb[i])
						addr_reg[i*8 +: 8] <= wdata[i*8 +: 8];
			end
			if (awaddr == flash_pkg::REG_WDATA) begin
				if (wstrb[0])
					wdata_reg[7:0] <= wdata[7:0];
				if (wstrb[1])
					wdata_reg[15:8] <= wdata[15:8];
			end
		end
		if (rdata_valid)
			rdata_reg <= op_rdata;
	end

	// sticky completion bits, cleared when the next operation starts
	always_ff @(posedge clk) begin
		if (reset || start) begin
			done_bit <= 1'b0;
			erase_bit <= 1'b0;
			program_bit <= 1'b0;
			vpp_bit <= 1'b0;
		end else if (done) begin
			done_bit <= 1'b1;
			erase_bit <= erase_err;
			program_bit <= program_err;
			vpp_bit <= vpp_err;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (arready)
				rvalid <= 1'b1;
			else if (rvalid && rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (arready) begin
			rresp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
			case (araddr)
				flash_pkg::REG_ADDR: rdata <= addr_reg;
				flash_pkg::REG_WDATA: rdata <= {16'd0, wdata_reg};
				flash_pkg::REG_STATUS: rdata <= status_word;
				flash_pkg::REG_RDATA: rdata <= {16'd0, rdata_reg};
				default: rdata <= 32'd0;
			endcase
		end
	end

endmodule

//--- logic/flash_cmd_seq.sv
`timescale 1ns/1ps

module flash_cmd_seq #(
	parameter int ADDR_WIDTH = 22,
	parameter int READ_WAIT = 4
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    start,
	input  logic [1:0]              op,
	input  logic [ADDR_WIDTH-1:0]   addr,
	input  logic [15:0]             wdata,
	input  flash_pkg::flash_word_t  captured_word,
	output logic                    busy,
	output logic                    done,
	output logic                    rdata_valid,
	output logic [15:0]             rdata,
	output logic                    erase_err,
	output logic                    program_err,
	output logic                    vpp_err,
	output logic                    we_n,
	output logic                    oe_n,
	output logic                    dq_drive,
	output logic [15:0]             dq_word,
	output logic [ADDR_WIDTH-1:0]   addr_latch
);

	localparam int CNT_W = (READ_WAIT < 1) ? 1 : $clog2(READ_WAIT + 1);

	localparam logic [3:0] IDLE = 4'd0;
	localparam logic [3:0] CMD1_LO = 4'd1;
	localparam logic [3:0] CMD1_HI = 4'd2;
	localparam logic [3:0] CMD2_LO = 4'd3;
	localparam logic [3:0] CMD2_HI = 4'd4;
	localparam logic [3:0] RD_WAIT = 4'd5;
	localparam logic [3:0] SR_LO = 4'd6;
	localparam logic [3:0] SR_HI = 4'd7;
	localparam logic [3:0] SR_OE = 4'd8;
	localparam logic [3:0] SR_CHECK = 4'd9;
	localparam logic [3:0] CLR_LO = 4'd10;
	localparam logic [3:0] CLR_HI = 4'd11;
	localparam logic [3:0] DONE = 4'd12;

	logic [3:0]       state;
	logic [1:0]       op_q;
	logic [15:0]      data_q;
	logic [CNT_W-1:0] wait_cnt;
	logic             any_err;

	assign any_err = captured_word.status[flash_pkg::SR_ERASE_ERR]
		| captured_word.status[flash_pkg::SR_PROGRAM_ERR]
		| captured_word.status[flash_pkg::SR_VPP_ERR];

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			erase_err <= 1'b0;
			program_err <= 1'b0;
			vpp_err <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						state <= CMD1_LO;
						erase_err <= 1'b0;
						program_err <= 1'b0;
						vpp_err <= 1'b0;
					end
				end
				CMD1_LO: state <= CMD1_HI;
				CMD1_HI: state <= (op_q == flash_pkg::OP_READ) ? RD_WAIT : CMD2_LO;
				CMD2_LO: state <= CMD2_HI;
				CMD2_HI: state <= SR_LO;
				RD_WAIT: begin
					if (wait_cnt == CNT_W'(READ_WAIT))
						state <= DONE;
				end
				SR_LO: state <= SR_HI;
				SR_HI: state <= SR_OE;
				SR_OE: state <= SR_CHECK;
				// poll again until the flash reports ready
				SR_CHECK: begin
					if (captured_word.status[flash_pkg::SR_READY]) begin
						erase_err <= captured_word.status[flash_pkg::SR_ERASE_ERR];
						program_err <= captured_word.status[flash_pkg::SR_PROGRAM_ERR];
						vpp_err <= captured_word.status[flash_pkg::SR_VPP_ERR];
						state <= any_err ? CLR_LO : DONE;
					end else begin
						state <= SR_LO;
					end
				end
				CLR_LO: state <= CLR_HI;
				CLR_HI: state <= DONE;
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && start) begin
			op_q <= op;
			data_q <= wdata;
			addr_latch <= addr;
		end
		if (state == CMD1_HI)
			wait_cnt <= '0;
		else if (state == RD_WAIT)
			wait_cnt <= wait_cnt + 1'b1;
	end

	assign busy = (state != IDLE);
	assign done = (state == DONE);
	assign rdata_valid = done && (op_q == flash_pkg::OP_READ);
	assign rdata = captured_word.data;

	assign we_n = !(state inside {CMD1_LO, CMD2_LO, SR_LO, CLR_LO});
	assign oe_n = !(state inside {RD_WAIT, SR_OE});
	// data held through the high half so it is stable at the we_n rising edge
	assign dq_drive = state inside {CMD1_LO, CMD1_HI, CMD2_LO, CMD2_HI,
		SR_LO, SR_HI, CLR_LO, CLR_HI};

	always_comb begin
		case (state)
			CMD1_LO, CMD1_HI: begin
				case (op_q)
					flash_pkg::OP_PROGRAM: dq_word = flash_pkg::CMD_PROGRAM;
					flash_pkg::OP_ERASE: dq_word = flash_pkg::CMD_ERASE_SETUP;
					default: dq_word = flash_pkg::CMD_READ_ARRAY;
				endcase
			end
			CMD2_LO, CMD2_HI: begin
				if (op_q == flash_pkg::OP_PROGRAM)
					dq_word = data_q;
				else
					dq_word = flash_pkg::CMD_ERASE_CONFIRM;
			end
			CLR_LO, CLR_HI: dq_word = flash_pkg::CMD_CLEAR_STATUS;
			default: dq_word = flash_pkg::CMD_READ_STATUS;
		endcase
	end

endmodule

//--- logic/flash_pin_if.sv
`timescale 1ns/1ps

module flash_pin_if #(
	parameter int ADDR_WIDTH = 22
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [ADDR_WIDTH-1:0]  addr_latch,
	input  logic                   we_n,
	input  logic                   oe_n,
	input  logic                   dq_drive,
	input  logic [15:0]            dq_word,
	input  logic [15:0]            flash_dq_in,
	output flash_pkg::flash_word_t captured_word,
	output logic [ADDR_WIDTH:0]    flash_addr,
	output logic [15:0]            flash_dq_out,
	output logic                   flash_dq_oe,
	output logic                   flash_ce_n,
	output logic                   flash_oe_n,
	output logic                   flash_we_n,
	output logic                   flash_rp_n,
	output logic                   flash_vpen,
	output logic                   flash_byte_n
);

	logic turnaround;

	// word address to byte address, bit 0 unused in word mode
	assign flash_addr = {addr_latch, 1'b0};

	assign flash_ce_n = 1'b0;
	assign flash_rp_n = 1'b1;
	assign flash_vpen = 1'b1;
	assign flash_byte_n = 1'b1;

	assign flash_we_n = we_n;
	assign flash_oe_n = oe_n;
	assign flash_dq_out = dq_word;

	// one idle cycle after the flash drove the bus before we drive it again
	always_ff @(posedge clk) begin
		if (reset)
			turnaround <= 1'b0;
		else
			turnaround <= !oe_n;
	end

	assign flash_dq_oe = dq_drive && oe_n && !turnaround;

	always_ff @(posedge clk) begin
		if (!oe_n)
			captured_word.data <= flash_dq_in;
	end

endmodule

//--- logic/flash_ctrl_top.sv
`timescale 1ns/1ps

module flash_ctrl_top #(
	parameter int ADDR_WIDTH = 22,
	parameter int READ_WAIT = 4
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [7:0]            awaddr,
	input  logic                  awvalid,
	output logic                  awready,
	input  logic [31:0]           wdata,
	input  logic [3:0]            wstrb,
	input  logic                  wvalid,
	output logic                  wready,
	output logic [1:0]            bresp,
	output logic                  bvalid,
	input  logic                  bready,
	input  logic [7:0]            araddr,
	input  logic                  arvalid,
	output logic                  arready,
	output logic [31:0]           rdata,
	output logic [1:0]            rresp,
	output logic                  rvalid,
	input  logic                  rready,
	output logic [ADDR_WIDTH:0]   flash_addr,
	output logic [15:0]           flash_dq_out,
	output logic                  flash_dq_oe,
	input  logic [15:0]           flash_dq_in,
	output logic                  flash_ce_n,
	output logic                  flash_oe_n,
	output logic                  flash_we_n,
	output logic                  flash_rp_n,
	output logic                  flash_vpen,
	output logic                  flash_byte_n
);

	logic                   start;
	logic [1:0]             op;
	logic [ADDR_WIDTH-1:0]  req_addr;
	logic [15:0]            req_wdata;
	logic                   busy;
	logic                   done;
	logic                   rdata_valid;
	logic [15:0]            seq_rdata;
	logic                   erase_err;
	logic                   program_err;
	logic                   vpp_err;
	logic                   we_n;
	logic                   oe_n;
	logic                   dq_drive;
	logic [15:0]            dq_word;
	logic [ADDR_WIDTH-1:0]  addr_latch;
	flash_pkg::flash_word_t captured_word;

	flash_axil_regs #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_regs (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.busy(busy),
		.done(done),
		.rdata_valid(rdata_valid),
		.op_rdata(seq_rdata),
		.erase_err(erase_err),
		.program_err(program_err),
		.vpp_err(vpp_err),
		.start(start),
		.op(op),
		.addr(req_addr),
		.op_wdata(req_wdata)
	);

	flash_cmd_seq #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.READ_WAIT(READ_WAIT)
	) u_seq (
		.clk(clk),
		.reset(reset),
		.start(start),
		.op(op),
		.addr(req_addr),
		.wdata(req_wdata),
		.captured_word(captured_word),
		.busy(busy),
		.done(done),
		.rdata_valid(rdata_valid),
		.rdata(seq_rdata),
		.erase_err(erase_err),
		.program_err(program_err),
		.vpp_err(vpp_err),
		.we_n(we_n),
		.oe_n(oe_n),
		.dq_drive(dq_drive),
		.dq_word(dq_word),
		.addr_latch(addr_latch)
	);

	flash_pin_if #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_pins (
		.clk(clk),
		.reset(reset),
		.addr_latch(addr_latch),
		.we_n(we_n),
		.oe_n(oe_n),
		.dq_drive(dq_drive),
		.dq_word(dq_word),
		.flash_dq_in(flash_dq_in),
		.captured_word(captured_word),
		.flash_addr(flash_addr),
		.flash_dq_out(flash_dq_out),
		.flash_dq_oe(flash_dq_oe),
		.flash_ce_n(flash_ce_n),
		.flash_oe_n(flash_oe_n),
		.flash_we_n(flash_we_n),
		.flash_rp_n(flash_rp_n),
		.flash_vpen(flash_vpen),
		.flash_byte_n(flash_byte_n)
	);

endmodule

//--- verif/flash_model.sv
`timescale 1ns/1ps

module flash_model #(
	parameter int ADDR_WIDTH = 22,
	parameter int PROGRAM_BUSY = 20,
	parameter int ERASE_BUSY = 40,
	parameter int PROTECTED_BLOCK = 3
) (
	input  logic                clk,
	input  logic [ADDR_WIDTH:0] flash_addr,
	input  logic [15:0]         flash_dq_out,
	input  logic                flash_dq_oe,
	output logic [15:0]         flash_dq_in,
	input  logic                flash_ce_n,
	input  logic                flash_oe_n,
	input  logic                flash_we_n,
	output logic                bus_conflict
);

	// sparse array, words never written read as erased
	logic [15:0] mem [int];
	logic        status_mode = 1'b0;
	// 0 none, 1 program data next, 2 erase confirm next
	logic [1:0]  pending = 2'd0;
	logic        erase_err = 1'b0;
	logic        program_err = 1'b0;
	logic        conflict_seen = 1'b0;
	int          busy_cnt = 0;
	int          word_addr;
	int          block;

	assign word_addr = int'(flash_addr[ADDR_WIDTH:1]);
	// 64K-word blocks
	assign block = word_addr >>> 16;
	assign bus_conflict = conflict_seen;

	function automatic logic [15:0] read_word(input int a);
		if (mem.exists(a))
			return mem[a];
		return 16'hFFFF;
	endfunction

	function automatic logic [15:0] status_word();
		status_word = 16'h0000;
		status_word[7] = (busy_cnt == 0);
		status_word[5] = erase_err;
		status_word[4] = program_err;
	endfunction

	task automatic decode(input logic [15:0] d);
		if (pending == 2'd1) begin
			pending = 2'd0;
			status_mode = 1'b1;
			busy_cnt = PROGRAM_BUSY;
			// programming can only clear bits
			if (block == PROTECTED_BLOCK)
				program_err = 1'b1;
			else
				mem[word_addr] = read_word(word_addr) & d;
		end else if (pending == 2'd2) begin
			pending = 2'd0;
			status_mode = 1'b1;
			busy_cnt = ERASE_BUSY;
			if (d != flash_pkg::CMD_ERASE_CONFIRM || block == PROTECTED_BLOCK) begin
				erase_err = 1'b1;
			end else begin
				foreach (mem[key])
					if ((key >>> 16) == block)
						mem[key] = 16'hFFFF;
			end
		end else begin
			case (d)
				flash_pkg::CMD_READ_ARRAY: status_mode = 1'b0;
				flash_pkg::CMD_PROGRAM: pending = 2'd1;
				flash_pkg::CMD_ERASE_SETUP: pending = 2'd2;
				flash_pkg::CMD_READ_STATUS: status_mode = 1'b1;
				flash_pkg::CMD_CLEAR_STATUS: begin
					erase_err = 1'b0;
					program_err = 1'b0;
				end
				default: ;
			endcase
		end
	endtask

	always @(posedge clk) begin
		if (busy_cnt > 0)
			busy_cnt = busy_cnt - 1;
		if (flash_dq_oe && !flash_oe_n)
			conflict_seen = 1'b1;
		// a we_n low cycle always ends with its rising edge at this clock edge
		if (!flash_we_n && !flash_ce_n && flash_dq_oe)
			decode(flash_dq_out);
		if (status_mode)
			flash_dq_in <= status_word();
		else
			flash_dq_in <= read_word(word_addr);
	end

endmodule

//--- verif/flash_ctrl_tb.sv
`timescale 1ns/1ps

module flash_ctrl_tb;

	localparam int ADDR_WIDTH = 22;
	localparam int READ_WAIT = 4;
	localparam int TIMEOUT = 2000;
	localparam logic [31:0] ST_DONE = 32'h0000_0002;
	localparam logic [31:0] ST_PROGRAM_ERR = 32'h0000_000A;
	localparam logic [31:0] ST_ERASE_ERR = 32'h0000_0012;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic                clk = 1'b0;
	logic                reset;
	logic [7:0]          awaddr;
	logic                awvalid;
	logic                awready;
	logic [31:0]         wdata;
	logic [3:0]          wstrb;
	logic                wvalid;
	logic                wready;
	logic [1:0]          bresp;
	logic                bvalid;
	logic                bready;
	logic [7:0]          araddr;
	logic                arvalid;
	logic                arready;
	logic [31:0]         rdata;
	logic [1:0]          rresp;
	logic                rvalid;
	logic                rready;
	logic [ADDR_WIDTH:0] flash_addr;
	logic [15:0]         flash_dq_out;
	logic                flash_dq_oe;
	logic [15:0]         flash_dq_in;
	logic                flash_ce_n;
	logic                flash_oe_n;
	logic                flash_we_n;
	logic                flash_rp_n;
	logic                flash_vpen;
	logic                flash_byte_n;
	logic                bus_conflict;

	int     errors = 0;
	int     checks = 0;
	integer seed = 27;
	bit     timed_out = 1'b0;

	// stimulus table as parallel queues with one entry per row
	string       row_name[$];
	logic [1:0]  row_op[$];
	logic [31:0] row_addr[$];
	logic [15:0] row_data[$];
	logic [15:0] row_rdata[$];
	logic [31:0] row_status[$];
	logic [15:0] shadow [int];

	always #2 clk = ~clk;

	flash_ctrl_top #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.READ_WAIT(READ_WAIT)
	) u_flash_ctrl_top (
		.clk(clk), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.flash_addr(flash_addr), .flash_dq_out(flash_dq_out), .flash_dq_oe(flash_dq_oe),
		.flash_dq_in(flash_dq_in), .flash_ce_n(flash_ce_n), .flash_oe_n(flash_oe_n),
		.flash_we_n(flash_we_n), .flash_rp_n(flash_rp_n), .flash_vpen(flash_vpen),
		.flash_byte_n(flash_byte_n)
	);

	flash_model #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_flash_model (
		.clk(clk), .flash_addr(flash_addr), .flash_dq_out(flash_dq_out),
		.flash_dq_oe(flash_dq_oe), .flash_dq_in(flash_dq_in), .flash_ce_n(flash_ce_n),
		.flash_oe_n(flash_oe_n), .flash_we_n(flash_we_n), .bus_conflict(bus_conflict)
	);

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic report_timeout(input string what);
		timed_out = 1'b1;
		errors++;
		$display("Timeout while waiting for %s", what);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (timed_out)
			return;
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic axil_write(input logic [7:0] a, input logic [31:0] d, output logic [1:0] resp);
		int n;
		resp = RESP_SLVERR;
		if (timed_out)
			return;
		awaddr = a;
		wdata = d;
		wstrb = 4'hF;
		awvalid = 1'b1;
		wvalid = 1'b1;
		n = 0;
		while ((awready !== 1'b1 || wready !== 1'b1) && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (awready !== 1'b1 || wready !== 1'b1) begin
			report_timeout("awready and wready");
			return;
		end
		// handshake edge
		next_cycle();
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b1;
		n = 0;
		while (bvalid !== 1'b1 && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (bvalid !== 1'b1) begin
			report_timeout("bvalid");
			return;
		end
		resp = bresp;
		next_cycle();
		bready = 1'b0;
	endtask

	task automatic axil_read(input logic [7:0] a, output logic [31:0] d, output logic [1:0] resp);
		int n;
		d = 32'd0;
		resp = RESP_SLVERR;
		if (timed_out)
			return;
		araddr = a;
		arvalid = 1'b1;
		n = 0;
		while (arready !== 1'b1 && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (arready !== 1'b1) begin
			report_timeout("arready");
			return;
		end
		next_cycle();
		arvalid = 1'b0;
		rready = 1'b1;
		n = 0;
		while (rvalid !== 1'b1 && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (rvalid !== 1'b1) begin
			report_timeout("rvalid");
			return;
		end
		d = rdata;
		resp = rresp;
		next_cycle();
		rready = 1'b0;
	endtask

	task automatic wait_idle(output logic [31:0] st);
		int n;
		logic [1:0] resp;
		n = 0;
		st = 32'h0000_0001;
		while (st[0] !== 1'b0 && n < TIMEOUT && !timed_out) begin
			axil_read(flash_pkg::REG_STATUS, st, resp);
			n++;
		end
		if (st[0] !== 1'b0 && !timed_out)
			report_timeout("busy to clear");
	endtask

	task automatic flash_op(input logic [1:0] op, input logic [31:0] a, input logic [15:0] d,
		output logic [31:0] st, output logic [15:0] rd);
		logic [1:0]  resp;
		logic [31:0] rword;
		rd = 16'h0000;
		axil_write(flash_pkg::REG_ADDR, a, resp);
		if (op == flash_pkg::OP_PROGRAM)
			axil_write(flash_pkg::REG_WDATA, {16'd0, d}, resp);
		axil_write(flash_pkg::REG_CMD, {30'd0, op}, resp);
		wait_idle(st);
		if (op == flash_pkg::OP_READ) begin
			axil_read(flash_pkg::REG_RDATA, rword, resp);
			rd = rword[15:0];
		end
	endtask

	task automatic add_row(input string name, input logic [1:0] op, input logic [31:0] a,
		input logic [15:0] d, input logic [15:0] exp_rd, input logic [31:0] exp_st);
		row_name.push_back(name);
		row_op.push_back(op);
		row_addr.push_back(a);
		row_data.push_back(d);
		row_rdata.push_back(exp_rd);
		row_status.push_back(exp_st);
	endtask

	function automatic logic [15:0] shadow_value(input logic [31:0] a);
		if (shadow.exists(int'(a)))
			return shadow[int'(a)];
		return 16'hFFFF;
	endfunction

	// 16 random words in blocks 4 and 5 with expected reads from the AND rule
	task automatic add_random_rows();
		logic [31:0] a;
		logic [15:0] d;
		logic [31:0] picks[$];
		add_row("erase blk4", flash_pkg::OP_ERASE, 32'h0004_0000, 16'h0, 16'h0, ST_DONE);
		add_row("erase blk5", flash_pkg::OP_ERASE, 32'h0005_0000, 16'h0, 16'h0, ST_DONE);
		for (int i = 0; i < 16; i++) begin
			a = 32'h0004_0000 + (32'($random(seed)) & 32'h0001_FFFF);
			d = 16'($random(seed));
			shadow[int'(a)] = shadow_value(a) & d;
			picks.push_back(a);
			add_row($sformatf("rand prog %0d", i), flash_pkg::OP_PROGRAM, a, d, 16'h0, ST_DONE);
		end
		for (int i = 0; i < 16; i++)
			add_row($sformatf("rand read %0d", i), flash_pkg::OP_READ, picks[i], 16'h0,
				shadow_value(picks[i]), ST_DONE);
	endtask

	initial begin
		logic [31:0] st;
		logic [31:0] rd;
		logic [15:0] fd;
		logic [1:0]  resp;
		reset = 1'b1;
		awaddr = 8'h00;
		awvalid = 1'b0;
		wdata = 32'd0;
		wstrb = 4'h0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = 8'h00;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		next_cycle();

		check_value("reset we_n", 32'd1, {31'd0, flash_we_n});
		check_value("reset oe_n", 32'd1, {31'd0, flash_oe_n});
		check_value("reset dq_oe", 32'd0, {31'd0, flash_dq_oe});
		check_value("ce_n tied active", 32'd0, {31'd0, flash_ce_n});
		check_value("rp_n released", 32'd1, {31'd0, flash_rp_n});
		check_value("vpen high", 32'd1, {31'd0, flash_vpen});
		check_value("byte_n word mode", 32'd1, {31'd0, flash_byte_n});
		axil_read(flash_pkg::REG_STATUS, st, resp);
		check_value("reset status", 32'd0, st);

		add_row("erase blk1", flash_pkg::OP_ERASE, 32'h0001_0000, 16'h0, 16'h0, ST_DONE);
		add_row("prog a", flash_pkg::OP_PROGRAM, 32'h0001_0010, 16'h1234, 16'h0, ST_DONE);
		add_row("prog b", flash_pkg::OP_PROGRAM, 32'h0001_0020, 16'hA5C3, 16'h0, ST_DONE);
		add_row("prog c", flash_pkg::OP_PROGRAM, 32'h0001_FFFF, 16'h0F0F, 16'h0, ST_DONE);
		add_row("read a", flash_pkg::OP_READ, 32'h0001_0010, 16'h0, 16'h1234, ST_DONE);
		add_row("read b", flash_pkg::OP_READ, 32'h0001_0020, 16'h0, 16'hA5C3, ST_DONE);
		add_row("read c", flash_pkg::OP_READ, 32'h0001_FFFF, 16'h0, 16'h0F0F, ST_DONE);
		add_row("reprog a", flash_pkg::OP_PROGRAM, 32'h0001_0010, 16'hFF00, 16'h0, ST_DONE);
		add_row("read a and", flash_pkg::OP_READ, 32'h0001_0010, 16'h0, 16'h1200, ST_DONE);
		add_row("prog blk2", flash_pkg::OP_PROGRAM, 32'h0002_0005, 16'hBEEF, 16'h0, ST_DONE);
		add_row("erase blk1 again", flash_pkg::OP_ERASE, 32'h0001_0400, 16'h0, 16'h0, ST_DONE);
		add_row("read a erased", flash_pkg::OP_READ, 32'h0001_0010, 16'h0, 16'hFFFF, ST_DONE);
		add_row("read b erased", flash_pkg::OP_READ, 32'h0001_0020, 16'h0, 16'hFFFF, ST_DONE);
		add_row("read c erased", flash_pkg::OP_READ, 32'h0001_FFFF, 16'h0, 16'hFFFF, ST_DONE);
		add_row("read blk2 kept", flash_pkg::OP_READ, 32'h0002_0005, 16'h0, 16'hBEEF, ST_DONE);
		add_row("prog protected", flash_pkg::OP_PROGRAM, 32'h0003_0001, 16'h0000, 16'h0,
			ST_PROGRAM_ERR);
		add_row("read protected", flash_pkg::OP_READ, 32'h0003_0001, 16'h0, 16'hFFFF, ST_DONE);
		add_row("erase protected", flash_pkg::OP_ERASE, 32'h0003_0000, 16'h0, 16'h0,
			ST_ERASE_ERR);
		add_row("read after erase err", flash_pkg::OP_READ, 32'h0003_0001, 16'h0, 16'hFFFF,
			ST_DONE);
		add_row("prog blk2 b", flash_pkg::OP_PROGRAM, 32'h0002_0006, 16'h5555, 16'h0, ST_DONE);
		add_random_rows();

		for (int i = 0; i < row_name.size(); i++) begin
			flash_op(row_op[i], row_addr[i], row_data[i], st, fd);
			check_value({row_name[i], " status"}, row_status[i], st);
			if (row_op[i] == flash_pkg::OP_READ)
				check_value({row_name[i], " rdata"}, {16'd0, row_rdata[i]}, {16'd0, fd});
		end

		axil_write(8'h14, 32'hDEAD_BEEF, resp);
		check_value("unmapped write bresp", {30'd0, RESP_SLVERR}, {30'd0, resp});
		axil_read(8'h14, rd, resp);
		check_value("unmapped read rresp", {30'd0, RESP_SLVERR}, {30'd0, resp});
		check_value("unmapped read data", 32'd0, rd);

		// second command lands while the first program is still polling
		axil_write(flash_pkg::REG_ADDR, 32'h0002_0010, resp);
		axil_write(flash_pkg::REG_WDATA, 32'h0000_00F0, resp);
		axil_write(flash_pkg::REG_CMD, {30'd0, flash_pkg::OP_PROGRAM}, resp);
		axil_write(flash_pkg::REG_ADDR, 32'h0002_0011, resp);
		axil_read(flash_pkg::REG_STATUS, st, resp);
		check_value("busy before second cmd", 32'd1, st & 32'd1);
		axil_write(flash_pkg::REG_CMD, {30'd0, flash_pkg::OP_PROGRAM}, resp);
		check_value("cmd while busy bresp", {30'd0, RESP_OKAY}, {30'd0, resp});
		wait_idle(st);
		check_value("first program status", ST_DONE, st);
		flash_op(flash_pkg::OP_READ, 32'h0002_0010, 16'h0, st, fd);
		check_value("first program data", 32'h0000_00F0, {16'd0, fd});
		flash_op(flash_pkg::OP_READ, 32'h0002_0011, 16'h0, st, fd);
		check_value("ignored program data", 32'h0000_FFFF, {16'd0, fd});

		checks++;
		if (bus_conflict) begin
			errors++;
			$display("Controller drove the data bus while the flash output was enabled");
		end

		$display("errors: %0d, checks: %0d", errors, checks);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- filelist.f
logic/flash_pkg.sv
logic/flash_axil_regs.sv
logic/flash_cmd_seq.sv
logic/flash_pin_if.sv
logic/flash_ctrl_top.sv
verif/flash_model.sv
verif/flash_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the flash controller testbench with Verilator, run it, judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module flash_ctrl_tb -f filelist.f -o flash_ctrl_sim

./obj_dir/flash_ctrl_sim > sim.log
cat sim.log

if grep -q "=== PASS ===" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
